// File: Bender.yml
package:
  name: issue_stage

sources:
  - src/issue_pkg.sv
  - src/regfile.sv
  - src/scoreboard.sv
  - src/issue_read_operands.sv
  - src/issue_stage.sv
  - target: test
    files:
      - verif/issue_stage_checker.sv
      - verif/tb_issue_stage.sv

// File: compile.f
src/issue_pkg.sv
src/regfile.sv
src/scoreboard.sv
src/issue_read_operands.sv
src/issue_stage.sv
verif/issue_stage_checker.sv
verif/tb_issue_stage.sv

// File: src/issue_pkg.sv
// Shared widths, encodings and bundles for the in-order issue stage
package issue_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned REG_ADDR_BITS = 5;
    // Three bits of transaction ID, so at most eight scoreboard entries
    localparam int unsigned TRANS_ID_BITS = 3;

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------
    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_e;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_AND = 3'd3,
        OP_MUL = 3'd4
    } op_e;

    // ------------------------------------------------------------------
    // Instruction word, R-type and I-type views
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [6:0]               funct7;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]              imm12;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } i_type_t;

    // rs1 and rd occupy the same bits in both views
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
    } instr_u;

    // ------------------------------------------------------------------
    // Bundles between blocks
    // ------------------------------------------------------------------
    typedef struct packed {
        fu_e    fu;
        op_e    op;
        logic   use_imm;    // Selects the I-type view of instr
        instr_u instr;
    } decoded_instr_t;

    typedef struct packed {
        fu_e                      fu;
        op_e                      op;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          data;
    } wb_t;

    typedef struct packed {
        logic [REG_ADDR_BITS-1:0] rd;
        logic [XLEN-1:0]          data;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } commit_t;

    typedef struct packed {
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [REG_ADDR_BITS-1:0] rs2;
    } operand_req_t;

    typedef struct packed {
        logic            rs1_busy;
        logic            rs1_fwd_valid;
        logic            rs2_busy;
        logic            rs2_fwd_valid;
        logic [XLEN-1:0] rs1_fwd_data;
        logic [XLEN-1:0] rs2_fwd_data;
    } sb_operand_t;

endpackage

// File: src/issue_read_operands.sv
// Operand selection, RAW hazard check and registered dispatch to ALU or multiplier
`timescale 1ns/1ns

module issue_read_operands (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // From the scoreboard
    input  issue_pkg::decoded_instr_t           issue_instr_i,
    input  logic [issue_pkg::TRANS_ID_BITS-1:0] issue_trans_id_i,
    input  logic                                issue_valid_i,
    output logic                                issue_ack_o,
    // Operand lookup in scoreboard and register file
    output issue_pkg::operand_req_t             operand_req_o,
    input  issue_pkg::sb_operand_t              sb_operand_i,
    input  logic [issue_pkg::XLEN-1:0]          rf_rdata_a_i,
    input  logic [issue_pkg::XLEN-1:0]          rf_rdata_b_i,
    // Functional units
    output issue_pkg::fu_data_t                 fu_data_o,
    input  logic                                alu_ready_i,
    output logic                                alu_valid_o,
    input  logic                                mul_ready_i,
    output logic                                mul_valid_o
);

    logic [issue_pkg::XLEN-1:0] operand_a;
    logic [issue_pkg::XLEN-1:0] operand_b;
    logic [issue_pkg::XLEN-1:0] imm_sext;
    logic                       stall_a;
    logic                       stall_b;
    logic                       unit_ready;
    logic                       to_alu;

    // ------------------------------------------------------------------
    // Instruction decode
    // ------------------------------------------------------------------
    // rs1 is common to both views, rs2 only exists in R-type
    assign operand_req_o.rs1 = issue_instr_i.instr.r_type.rs1;
    assign operand_req_o.rs2 = issue_instr_i.instr.r_type.rs2;

    // Sign-extended I-type immediate
    assign imm_sext = {{(issue_pkg::XLEN-12){issue_instr_i.instr.i_type.imm12[11]}},
                       issue_instr_i.instr.i_type.imm12};

    // ------------------------------------------------------------------
    // Operand selection
    // ------------------------------------------------------------------
    // Forwarded result beats the register file
    assign operand_a = sb_operand_i.rs1_fwd_valid ? sb_operand_i.rs1_fwd_data
                                                  : rf_rdata_a_i;

    always_comb begin
        if (issue_instr_i.use_imm) begin
            operand_b = imm_sext;
        end else if (sb_operand_i.rs2_fwd_valid) begin
            operand_b = sb_operand_i.rs2_fwd_data;
        end else begin
            operand_b = rf_rdata_b_i;
        end
    end

    // Producer still in flight without a result
    assign stall_a = sb_operand_i.rs1_busy;
    assign stall_b = sb_operand_i.rs2_busy & ~issue_instr_i.use_imm;

    // ------------------------------------------------------------------
    // Dispatch
    // ------------------------------------------------------------------
    assign to_alu     = (issue_instr_i.fu == issue_pkg::FU_ALU);
    assign unit_ready = to_alu ? alu_ready_i : mul_ready_i;

    assign issue_ack_o = issue_valid_i & ~stall_a & ~stall_b & unit_ready;

    // One-cycle valid pulse towards the selected unit
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_valid_o <= 1'b0;
            mul_valid_o <= 1'b0;
        end else begin
            alu_valid_o <= issue_ack_o & to_alu;
            mul_valid_o <= issue_ack_o & ~to_alu;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_ack_o) begin
            fu_data_o.fu        <= issue_instr_i.fu;
            fu_data_o.op        <= issue_instr_i.op;
            fu_data_o.operand_a <= operand_a;
            fu_data_o.operand_b <= operand_b;
            fu_data_o.trans_id  <= issue_trans_id_i;
        end
    end

endmodule

// File: src/issue_stage.sv
// In-order issue stage: scoreboard, register file and operand read with dispatch
`timescale 1ns/1ns

module issue_stage #(
    parameter int unsigned NR_ENTRIES = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // Decode
    input  issue_pkg::decoded_instr_t decoded_instr_i,
    input  logic                      decoded_valid_i,
    output logic                      decoded_ack_o,
    output logic                      sb_full_o,
    // Functional units
    output issue_pkg::fu_data_t       fu_data_o,
    output logic                      alu_valid_o,
    input  logic                      alu_ready_i,
    output logic                      mul_valid_o,
    input  logic                      mul_ready_i,
    // Write-back
    input  issue_pkg::wb_t            wb_i,
    // Commit
    output issue_pkg::commit_t        commit_o,
    output logic                      commit_valid_o,
    input  logic                      commit_ack_i
);

    // ------------------------------------------------------------------
    // Scoreboard <-> read operands
    // ------------------------------------------------------------------
    issue_pkg::decoded_instr_t           issue_instr;
    logic [issue_pkg::TRANS_ID_BITS-1:0] issue_trans_id;
    logic                                issue_valid;
    logic                                issue_ack;
    issue_pkg::operand_req_t             operand_req;
    issue_pkg::sb_operand_t              sb_operand;

    // Register file read data
    logic [issue_pkg::XLEN-1:0] rf_rdata_a;
    logic [issue_pkg::XLEN-1:0] rf_rdata_b;

    // Commit write into the register file
    logic rf_we;

    assign rf_we = commit_valid_o & commit_ack_i;

    scoreboard #(
        .NR_ENTRIES ( NR_ENTRIES )
    ) u_scoreboard (
        .clk_i            ( clk_i           ),
        .rst_n_i          ( rst_n_i         ),
        .decoded_instr_i  ( decoded_instr_i ),
        .decoded_valid_i  ( decoded_valid_i ),
        .decoded_ack_o    ( decoded_ack_o   ),
        .sb_full_o        ( sb_full_o       ),
        .issue_instr_o    ( issue_instr     ),
        .issue_trans_id_o ( issue_trans_id  ),
        .issue_valid_o    ( issue_valid     ),
        .issue_ack_i      ( issue_ack       ),
        .operand_req_i    ( operand_req     ),
        .sb_operand_o     ( sb_operand      ),
        .wb_i             ( wb_i            ),
        .commit_o         ( commit_o        ),
        .commit_valid_o   ( commit_valid_o  ),
        .commit_ack_i     ( commit_ack_i    )
    );

    regfile u_regfile (
        .clk_i     ( clk_i           ),
        .rst_n_i   ( rst_n_i         ),
        .raddr_a_i ( operand_req.rs1 ),
        .raddr_b_i ( operand_req.rs2 ),
        .rdata_a_o ( rf_rdata_a      ),
        .rdata_b_o ( rf_rdata_b      ),
        .waddr_i   ( commit_o.rd     ),
        .wdata_i   ( commit_o.data   ),
        .we_i      ( rf_we           )
    );

    issue_read_operands u_issue_read_operands (
        .clk_i            ( clk_i          ),
        .rst_n_i          ( rst_n_i        ),
        .issue_instr_i    ( issue_instr    ),
        .issue_trans_id_i ( issue_trans_id ),
        .issue_valid_i    ( issue_valid    ),
        .issue_ack_o      ( issue_ack      ),
        .operand_req_o    ( operand_req    ),
        .sb_operand_i     ( sb_operand     ),
        .rf_rdata_a_i     ( rf_rdata_a     ),
        .rf_rdata_b_i     ( rf_rdata_b     ),
        .fu_data_o        ( fu_data_o      ),
        .alu_ready_i      ( alu_ready_i    ),
        .alu_valid_o      ( alu_valid_o    ),
        .mul_ready_i      ( mul_ready_i    ),
        .mul_valid_o      ( mul_valid_o    )
    );

endmodule

// File: src/regfile.sv
// Architectural integer register file, two read ports and one write port
`timescale 1ns/1ns

module regfile (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // Read ports
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] raddr_a_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] raddr_b_i,
    output logic [issue_pkg::XLEN-1:0]          rdata_a_o,
    output logic [issue_pkg::XLEN-1:0]          rdata_b_o,
    // Write port
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] waddr_i,
    input  logic [issue_pkg::XLEN-1:0]          wdata_i,
    input  logic                                we_i
);

    localparam int unsigned NR_REGS = 2 ** issue_pkg::REG_ADDR_BITS;

    // x0 has no storage
    logic [issue_pkg::XLEN-1:0] regs_q [1:NR_REGS-1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int unsigned i = 1; i < NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            for (int unsigned i = 1; i < NR_REGS; i++) begin
                if (we_i && (waddr_i == issue_pkg::REG_ADDR_BITS'(i))) begin
                    regs_q[i] <= wdata_i;
                end
            end
        end
    end

    // Combinational reads, x0 reads zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: src/scoreboard.sv
// Scoreboard holding in-flight instructions from decode to in-order commit
`timescale 1ns/1ns

module scoreboard #(
    parameter int unsigned NR_ENTRIES = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // Decode side
    input  issue_pkg::decoded_instr_t           decoded_instr_i,
    input  logic                                decoded_valid_i,
    output logic                                decoded_ack_o,
    output logic                                sb_full_o,
    // Towards the read-operand block
    output issue_pkg::decoded_instr_t           issue_instr_o,
    output logic [issue_pkg::TRANS_ID_BITS-1:0] issue_trans_id_o,
    output logic                                issue_valid_o,
    input  logic                                issue_ack_i,
    // Operand lookup
    input  issue_pkg::operand_req_t             operand_req_i,
    output issue_pkg::sb_operand_t              sb_operand_o,
    // Write-back and commit
    input  issue_pkg::wb_t                      wb_i,
    output issue_pkg::commit_t                  commit_o,
    output logic                                commit_valid_o,
    input  logic                                commit_ack_i
);

    localparam int unsigned PTR_BITS = $clog2(NR_ENTRIES);
    localparam int unsigned TID_BITS = issue_pkg::TRANS_ID_BITS;

    // Pointers: head commits, issue dispatches, tail allocates
    logic [PTR_BITS-1:0] head_q;
    logic [PTR_BITS-1:0] issue_q;
    logic [PTR_BITS-1:0] tail_q;

    // Per-entry state flags
    logic [NR_ENTRIES-1:0] valid_q;
    logic [NR_ENTRIES-1:0] issued_q;
    logic [NR_ENTRIES-1:0] done_q;

    // Entry payload
    issue_pkg::decoded_instr_t  instr_q  [NR_ENTRIES];
    logic [issue_pkg::XLEN-1:0] result_q [NR_ENTRIES];

    logic [PTR_BITS-1:0] wb_idx;
    logic [PTR_BITS-1:0] older_cnt;
    logic                do_alloc;
    logic                do_issue;
    logic                do_wb;
    logic                do_commit;

    // ------------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------------
    assign sb_full_o     = &valid_q;
    assign decoded_ack_o = decoded_valid_i & ~sb_full_o;
    assign do_alloc      = decoded_ack_o;

    // Oldest entry not yet handed to the read-operand block
    assign issue_valid_o    = valid_q[issue_q] & ~issued_q[issue_q];
    assign issue_instr_o    = instr_q[issue_q];
    assign issue_trans_id_o = TID_BITS'(issue_q);
    assign do_issue         = issue_valid_o & issue_ack_i;

    // Only an issued, unfinished entry takes a result
    assign wb_idx = wb_i.trans_id[PTR_BITS-1:0];
    assign do_wb  = wb_i.valid & valid_q[wb_idx] & issued_q[wb_idx] & ~done_q[wb_idx];

    assign commit_valid_o    = valid_q[head_q] & done_q[head_q];
    assign commit_o.rd       = instr_q[head_q].instr.r_type.rd;
    assign commit_o.data     = result_q[head_q];
    assign commit_o.trans_id = TID_BITS'(head_q);
    assign do_commit         = commit_valid_o & commit_ack_i;

    // ------------------------------------------------------------------
    // Operand lookup
    // ------------------------------------------------------------------
    // Number of entries between head and the issue entry
    assign older_cnt = issue_q - head_q;

    // Walk from oldest to youngest so the youngest match wins
    always_comb begin
        logic [PTR_BITS-1:0]                idx;
        logic [issue_pkg::REG_ADDR_BITS-1:0] rd;
        sb_operand_o = '0;
        for (int unsigned k = 0; k < NR_ENTRIES; k++) begin
            idx = head_q + PTR_BITS'(k);
            rd  = instr_q[idx].instr.r_type.rd;
            if ((k < older_cnt) && valid_q[idx] && (rd != '0)) begin
                if (rd == operand_req_i.rs1) begin
                    sb_operand_o.rs1_busy      = ~done_q[idx];
                    sb_operand_o.rs1_fwd_valid = done_q[idx];
                    sb_operand_o.rs1_fwd_data  = result_q[idx];
                end
                if (rd == operand_req_i.rs2) begin
                    sb_operand_o.rs2_busy      = ~done_q[idx];
                    sb_operand_o.rs2_fwd_valid = done_q[idx];
                    sb_operand_o.rs2_fwd_data  = result_q[idx];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // State update
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q   <= '0;
            issue_q  <= '0;
            tail_q   <= '0;
            valid_q  <= '0;
            issued_q <= '0;
            done_q   <= '0;
        end else begin
            if (do_alloc) begin
                valid_q[tail_q]  <= 1'b1;
                issued_q[tail_q] <= 1'b0;
                done_q[tail_q]   <= 1'b0;
                tail_q           <= tail_q + 1'b1;
            end
            if (do_issue) begin
                issued_q[issue_q] <= 1'b1;
                issue_q           <= issue_q + 1'b1;
            end
            if (do_wb) begin
                done_q[wb_idx] <= 1'b1;
            end
            // Head retires, the register file takes over at this edge
            if (do_commit) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_alloc) begin
            instr_q[tail_q] <= decoded_instr_i;
        end
        if (do_wb) begin
            result_q[wb_idx] <= wb_i.data;
        end
    end

endmodule

// File: verif/issue_stage_checker.sv
// Concurrent assertions on the issue stage dispatch, commit and decode handshakes
`timescale 1ns/1ns

module issue_stage_checker (
    input logic                      clk_i,
    input logic                      rst_n_i,
    input logic                      alu_valid_o,
    input logic                      mul_valid_o,
    input issue_pkg::commit_t        commit_o,
    input logic                      commit_valid_o,
    input logic                      commit_ack_i,
    input logic                      decoded_ack_o,
    input logic                      sb_full_o
);

    // At most one unit receives an instruction per cycle
    a_single_dispatch: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(alu_valid_o && mul_valid_o)
    ) else $error("ALU and multiplier valid are high together");

    // Commit payload holds until it is acknowledged
    a_commit_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (commit_valid_o && !commit_ack_i) |=> (commit_valid_o && $stable(commit_o))
    ) else $error("Commit dropped or changed before acknowledge");

    a_no_ack_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(decoded_ack_o && sb_full_o)
    ) else $error("Decode acknowledged while the scoreboard is full");

endmodule

// File: verif/tb_issue_stage.sv
// Testbench for the issue stage with a random instruction stream and an in-order model
`timescale 1ns/1ns

module tb_issue_stage;

    localparam int unsigned NR_ENTRIES = 4;
    localparam int unsigned NUM_INSTR  = 300;
    localparam int unsigned IDLE_LIMIT = 500;

    // Expected behavior of one instruction in program order
    typedef struct packed {
        issue_pkg::fu_e fu;
        issue_pkg::op_e op;
        logic [31:0]    operand_a;
        logic [31:0]    operand_b;
        logic [31:0]    result;
        logic [4:0]     rd;
        logic [2:0]     trans_id;
    } expect_t;

    logic                      clk;
    logic                      rst_n;
    issue_pkg::decoded_instr_t decoded_instr;
    logic                      decoded_valid;
    logic                      decoded_ack;
    logic                      sb_full;
    issue_pkg::fu_data_t       fu_data;
    logic                      alu_valid;
    logic                      alu_ready;
    logic                      mul_valid;
    logic                      mul_ready;
    issue_pkg::wb_t            wb;
    issue_pkg::commit_t        commit;
    logic                      commit_valid;
    logic                      commit_ack;

    int unsigned check_errors;
    int unsigned timeout_errors;
    int unsigned n_acc;
    int unsigned n_com;
    int unsigned idle;
    logic        taken;
    expect_t     disp_q[$];
    expect_t     commit_q[$];
    logic [31:0] model_regs [32];

    // Results waiting in the functional units by transaction ID
    logic        slot_busy  [NR_ENTRIES];
    int unsigned slot_delay [NR_ENTRIES];
    logic [31:0] slot_data  [NR_ENTRIES];

    issue_stage #(
        .NR_ENTRIES ( NR_ENTRIES )
    ) u_issue_stage (
        .clk_i           ( clk           ),
        .rst_n_i         ( rst_n         ),
        .decoded_instr_i ( decoded_instr ),
        .decoded_valid_i ( decoded_valid ),
        .decoded_ack_o   ( decoded_ack   ),
        .sb_full_o       ( sb_full       ),
        .fu_data_o       ( fu_data       ),
        .alu_valid_o     ( alu_valid     ),
        .alu_ready_i     ( alu_ready     ),
        .mul_valid_o     ( mul_valid     ),
        .mul_ready_i     ( mul_ready     ),
        .wb_i            ( wb            ),
        .commit_o        ( commit        ),
        .commit_valid_o  ( commit_valid  ),
        .commit_ack_i    ( commit_ack    )
    );

    bind issue_stage issue_stage_checker u_checker (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .alu_valid_o    ( alu_valid_o    ),
        .mul_valid_o    ( mul_valid_o    ),
        .commit_o       ( commit_o       ),
        .commit_valid_o ( commit_valid_o ),
        .commit_ack_i   ( commit_ack_i   ),
        .decoded_ack_o  ( decoded_ack_o  ),
        .sb_full_o      ( sb_full_o      )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] fu_result(issue_pkg::op_e op, logic [31:0] a,
                                              logic [31:0] b);
        case (op)
            issue_pkg::OP_ADD: return a + b;
            issue_pkg::OP_SUB: return a - b;
            issue_pkg::OP_XOR: return a ^ b;
            issue_pkg::OP_AND: return a & b;
            default:           return a * b;
        endcase
    endfunction

    // Only x0 to x3 so that hazards are frequent
    function automatic logic [4:0] pick_reg();
        return 5'($urandom % 4);
    endfunction

    function automatic issue_pkg::decoded_instr_t make_instr();
        issue_pkg::decoded_instr_t d;
        d = '0;
        d.instr.r_type.funct7 = 7'($urandom);
        d.instr.r_type.rs2    = pick_reg();
        d.instr.r_type.rs1    = pick_reg();
        d.instr.r_type.funct3 = 3'($urandom);
        d.instr.r_type.rd     = pick_reg();
        d.instr.r_type.opcode = 7'h33;
        if ($urandom % 4 == 0) begin
            d.fu = issue_pkg::FU_MUL;
            d.op = issue_pkg::OP_MUL;
        end else begin
            d.fu = issue_pkg::FU_ALU;
            d.op = issue_pkg::op_e'($urandom % 4);
        end
        d.use_imm = ($urandom % 3 == 0);
        // Immediate overwrites funct7 and rs2
        if (d.use_imm) begin
            d.instr.i_type.imm12  = 12'($urandom);
            d.instr.i_type.opcode = 7'h13;
        end
        return d;
    endfunction

    task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            check_errors++;
        end
    endtask

    task automatic report_error(string what);
        $display("ERROR: %s", what);
        check_errors++;
    endtask

    // Reference model step in acceptance order
    task automatic accept_instr(issue_pkg::decoded_instr_t d);
        expect_t     e;
        logic [31:0] imm;
        imm = {{20{d.instr.i_type.imm12[11]}}, d.instr.i_type.imm12};
        e.fu        = d.fu;
        e.op        = d.op;
        e.operand_a = model_regs[d.instr.r_type.rs1];
        e.operand_b = d.use_imm ? imm : model_regs[d.instr.r_type.rs2];
        e.result    = fu_result(d.op, e.operand_a, e.operand_b);
        e.rd        = d.instr.r_type.rd;
        e.trans_id  = 3'(n_acc % NR_ENTRIES);
        if (e.rd != 5'd0) begin
            model_regs[e.rd] = e.result;
        end
        disp_q.push_back(e);
        commit_q.push_back(e);
        n_acc++;
    endtask

    // ------------------------------------------------------------------
    // Input drivers just after the rising edge
    // ------------------------------------------------------------------
    task automatic drive_inputs();
        int unsigned start;
        int unsigned idx;
        logic        found;
        if (taken) begin
            decoded_valid = 1'b0;
            taken         = 1'b0;
        end
        if (!decoded_valid && (n_acc < NUM_INSTR) && ($urandom % 4 != 0)) begin
            decoded_instr = make_instr();
            decoded_valid = 1'b1;
        end
        alu_ready = ($urandom % 4 != 0);
        mul_ready = ($urandom % 2 == 0);
        // Out-of-order write-back of one finished result
        wb    = '0;
        found = 1'b0;
        start = $urandom % NR_ENTRIES;
        for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
            if (slot_busy[i] && slot_delay[i] > 0) begin
                slot_delay[i]--;
            end
        end
        for (int unsigned k = 0; k < NR_ENTRIES; k++) begin
            idx = (start + k) % NR_ENTRIES;
            if (!found && slot_busy[idx] && slot_delay[idx] == 0) begin
                wb.valid     = 1'b1;
                wb.trans_id  = 3'(idx);
                wb.data      = slot_data[idx];
                slot_busy[idx] = 1'b0;
                found        = 1'b1;
            end
        end
        commit_ack = commit_valid && ($urandom % 2 == 0);
    endtask

    // ------------------------------------------------------------------
    // Observation at the falling edge before the next transfer
    // ------------------------------------------------------------------
    task automatic observe_outputs();
        expect_t e;
        compare_value("sb_full", (n_acc - n_com) == NR_ENTRIES, sb_full);
        compare_value("decoded_ack",
                      decoded_valid && ((n_acc - n_com) != NR_ENTRIES), decoded_ack);
        if (decoded_valid && decoded_ack) begin
            accept_instr(decoded_instr);
            taken = 1'b1;
        end
        if (alu_valid || mul_valid) begin
            if (disp_q.size() == 0) begin
                report_error("dispatch seen with no instruction outstanding");
            end else begin
                e = disp_q.pop_front();
                compare_value("dispatch_alu_valid", e.fu == issue_pkg::FU_ALU, alu_valid);
                compare_value("dispatch_mul_valid", e.fu == issue_pkg::FU_MUL, mul_valid);
                compare_value("dispatch_fu", e.fu, fu_data.fu);
                compare_value("dispatch_op", e.op, fu_data.op);
                compare_value("dispatch_operand_a", e.operand_a, fu_data.operand_a);
                compare_value("dispatch_operand_b", e.operand_b, fu_data.operand_b);
                compare_value("dispatch_trans_id", e.trans_id, fu_data.trans_id);
                if (slot_busy[fu_data.trans_id[1:0]]) begin
                    report_error("dispatch to a transaction ID still waiting for write-back");
                end
                slot_busy[fu_data.trans_id[1:0]]  = 1'b1;
                slot_delay[fu_data.trans_id[1:0]] = $urandom % 6;
                slot_data[fu_data.trans_id[1:0]]  =
                    fu_result(fu_data.op, fu_data.operand_a, fu_data.operand_b);
            end
        end
        if (commit_valid && commit_ack) begin
            idle = 0;
            if (commit_q.size() == 0) begin
                report_error("commit seen with no instruction outstanding");
            end else begin
                e = commit_q.pop_front();
                compare_value("commit_rd", e.rd, commit.rd);
                compare_value("commit_data", e.result, commit.data);
                compare_value("commit_trans_id", e.trans_id, commit.trans_id);
            end
            n_com++;
        end else begin
            idle++;
        end
    endtask

    initial begin
        int unsigned seed;
        seed           = 26957;
        seed           = $urandom(seed);
        rst_n          = 1'b0;
        decoded_instr  = '0;
        decoded_valid  = 1'b0;
        alu_ready      = 1'b0;
        mul_ready      = 1'b0;
        wb             = '0;
        commit_ack     = 1'b0;
        check_errors   = 0;
        timeout_errors = 0;
        n_acc          = 0;
        n_com          = 0;
        idle           = 0;
        taken          = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < NR_ENTRIES; i++) begin
            slot_busy[i]  = 1'b0;
            slot_delay[i] = 0;
            slot_data[i]  = '0;
        end
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
        @(negedge clk);
        compare_value("reset_alu_valid", 1'b0, alu_valid);
        compare_value("reset_mul_valid", 1'b0, mul_valid);
        compare_value("reset_commit_valid", 1'b0, commit_valid);
        compare_value("reset_sb_full", 1'b0, sb_full);
        while ((n_com < NUM_INSTR) && (timeout_errors == 0)) begin
            @(posedge clk);
            #2;
            drive_inputs();
            @(negedge clk);
            observe_outputs();
            if (idle > IDLE_LIMIT) begin
                $display("ERROR: timeout, no commit for %0d cycles", IDLE_LIMIT);
                timeout_errors++;
            end
        end
        $display("Committed %0d, check errors %0d, timeout errors %0d",
                 n_com, check_errors, timeout_errors);
        if ((check_errors == 0) && (timeout_errors == 0)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
